//--- common/chiplet_pkg.sv
package chiplet_pkg;

    // word and field widths.
    localparam int data_width = 32;
    localparam int node_w     = 4;
    localparam int len_w      = 8;
    localparam int count_w    = 8;
    localparam int strobe_w   = data_width / 8;

    localparam int head_rsvd_w   = data_width - 2 * node_w - len_w;
    localparam int status_rsvd_w = data_width - count_w - 4;

    // bus address map, byte offsets.
    localparam logic [7:0] addr_tx_head   = 8'h00;
    localparam logic [7:0] addr_tx_data   = 8'h04;
    localparam logic [7:0] addr_rx_data   = 8'h10;
    localparam logic [7:0] addr_rx_status = 8'h14;

    typedef enum logic [1:0] {
        kind_head = 2'd0,
        kind_body = 2'd1,
        kind_tail = 2'd2
    } flit_kind_e;

    // head view of a payload word.
    typedef struct packed {
        logic [node_w-1:0]      dest_node;
        logic [node_w-1:0]      src_node;
        logic [len_w-1:0]       length;    // body flits that follow.
        logic [head_rsvd_w-1:0] reserved;
    } head_t;

    // one payload word, read as a head or as plain data.
    typedef union packed {
        head_t                 head;
        logic [data_width-1:0] data;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_e    kind;
        flit_payload_u payload;
    } flit_t;

    // receive status word, rx_count in the low byte.
    typedef struct packed {
        logic [status_rsvd_w-1:0] pad;
        flit_kind_e               front_kind;
        logic                     empty;
        logic                     overflow;
        logic [count_w-1:0]       rx_count;
    } rx_status_t;

endpackage

//--- hdl/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo
    import chiplet_pkg::*;
#(
    parameter int depth = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  flit_t              push_flit,
    input  logic               pop,
    output flit_t              front_flit,
    output logic               full,
    output logic               empty,
    output logic [count_w-1:0] count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    flit_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full       = (count == count_w'(depth));
    assign empty      = (count == '0);
    assign do_push    = push && !full;  // push on full is dropped.
    assign do_pop     = pop && !empty;
    assign front_flit = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- endpoint/flit_packetizer.sv
`timescale 1ns/1ps

module flit_packetizer
    import chiplet_pkg::*;
#(
    parameter int addr_width = 32,
    parameter int node_id    = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    input  logic [strobe_w-1:0]   strobe,
    input  logic                  fifo_full,
    output logic                  push,
    output flit_t                 push_flit,
    output logic                  request_stall,
    output logic                  wr_error
);

    logic             pkt_open;
    logic [len_w-1:0] remaining;
    flit_payload_u    wr_word;
    logic             is_head;
    logic             is_data;
    logic             head_ok;
    logic             data_ok;
    logic             legal;
    logic             last_body;

    assign wr_word.data = wdata;

    assign is_head = (addr == addr_width'(addr_tx_head));
    assign is_data = (addr == addr_width'(addr_tx_data));

    // a new head needs a closed packet and a nonzero length.
    assign head_ok = is_head && !pkt_open && (wr_word.head.length != '0);
    assign data_ok = is_data && pkt_open;

    assign legal     = wen && (&strobe) && (head_ok || data_ok);
    assign last_body = (remaining == len_w'(1));

    assign push          = legal && !fifo_full;
    assign request_stall = legal && fifo_full;  // master holds the write.
    assign wr_error      = wen && !((&strobe) && (head_ok || data_ok));

    always_comb begin
        push_flit.kind         = last_body ? kind_tail : kind_body;
        push_flit.payload.data = wdata;
        if (is_head) begin
            push_flit.kind                   = kind_head;
            push_flit.payload.head.dest_node = wr_word.head.dest_node;
            push_flit.payload.head.src_node  = node_w'(node_id);
            push_flit.payload.head.length    = wr_word.head.length;
            push_flit.payload.head.reserved  = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_open  <= 1'b0;
            remaining <= '0;
        end else if (push) begin
            if (is_head) begin
                pkt_open  <= 1'b1;
                remaining <= wr_word.head.length;
            end else begin
                remaining <= remaining - 1'b1;
                if (last_body) begin
                    pkt_open <= 1'b0;  // tail closes the packet.
                end
            end
        end
    end

endmodule

//--- endpoint/rx_reader.sv
`timescale 1ns/1ps

module rx_reader
    import chiplet_pkg::*;
#(
    parameter int addr_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ren,
    input  logic [addr_width-1:0] addr,
    input  logic                  data_ready_in,
    input  logic                  fifo_full,
    input  logic                  fifo_empty,
    input  logic [count_w-1:0]    fifo_count,
    input  flit_t                 front_flit,
    output logic                  pop,
    output logic [data_width-1:0] rdata,
    output logic                  rd_error,
    output logic                  credit_return
);

    logic       overflow;
    logic       is_data;
    logic       is_status;
    rx_status_t status;

    assign is_data   = (addr == addr_width'(addr_rx_data));
    assign is_status = (addr == addr_width'(addr_rx_status));

    assign pop = ren && is_data && !fifo_empty;

    always_comb begin
        status            = '0;
        status.rx_count   = fifo_count;
        status.overflow   = overflow;
        status.empty      = fifo_empty;
        // front entry is stale when empty.
        status.front_kind = fifo_empty ? kind_head : front_flit.kind;
    end

    always_comb begin
        rdata = '0;
        if (pop) begin
            rdata = front_flit.payload.data;
        end else if (ren && is_status) begin
            rdata = status;
        end
    end

    assign rd_error = ren && ((is_data && fifo_empty) || !(is_data || is_status));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow      <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;  // one credit per drained flit.
            if (data_ready_in && fifo_full) begin
                overflow <= 1'b1;  // sticky until reset.
            end
        end
    end

endmodule

//--- hdl/credit_link_tx.sv
`timescale 1ns/1ps

module credit_link_tx
    import chiplet_pkg::*;
#(
    parameter int link_credits = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fifo_empty,
    input  flit_t front_flit,
    input  logic  credit_granted,
    output logic  pop,
    output flit_t out_flit,
    output logic  data_ready_out
);

    localparam int credit_w = $clog2(link_credits + 1);

    logic [credit_w-1:0] credits;
    logic                send;

    // one flit per cycle while the far end has room.
    assign send = !fifo_empty && (credits != '0);
    assign pop  = send;

    always_ff @(posedge clk) begin
        if (send) begin
            out_flit <= front_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits        <= credit_w'(link_credits);
            data_ready_out <= 1'b0;
        end else begin
            data_ready_out <= send;
            case ({send, credit_granted})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    if (credits != credit_w'(link_credits)) begin
                        credits <= credits + 1'b1;  // saturates at the limit.
                    end
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

//--- hdl/endpoint_node.sv
`timescale 1ns/1ps

module endpoint_node
    import chiplet_pkg::*;
#(
    parameter int addr_width   = 32,
    parameter int node_id      = 1,
    parameter int tx_depth     = 8,
    parameter int rx_depth     = 8,
    parameter int link_credits = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  logic                  ren,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    input  logic [strobe_w-1:0]   strobe,
    output logic [data_width-1:0] rdata,
    output logic                  error,
    output logic                  request_stall,
    input  flit_t                 in_flit,
    input  logic                  data_ready_in,
    output flit_t                 out_flit,
    output logic                  data_ready_out,
    input  logic                  credit_granted,
    output logic                  credit_return
);

    logic               tx_push;
    flit_t              tx_push_flit;
    logic               tx_pop;
    flit_t              tx_front;
    logic               tx_full;
    logic               tx_empty;
    logic               rx_pop;
    flit_t              rx_front;
    logic               rx_full;
    logic               rx_empty;
    logic [count_w-1:0] rx_count;
    logic               wr_error;
    logic               rd_error;

    assign error = wr_error | rd_error;

    flit_packetizer #(
        .addr_width(addr_width),
        .node_id   (node_id)
    ) u_packetizer (
        .clk          (clk),
        .rst_n        (rst_n),
        .wen          (wen),
        .addr         (addr),
        .wdata        (wdata),
        .strobe       (strobe),
        .fifo_full    (tx_full),
        .push         (tx_push),
        .push_flit    (tx_push_flit),
        .request_stall(request_stall),
        .wr_error     (wr_error)
    );

    flit_fifo #(
        .depth(tx_depth)
    ) u_tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_flit (tx_push_flit),
        .pop       (tx_pop),
        .front_flit(tx_front),
        .full      (tx_full),
        .empty     (tx_empty),
        .count     ()
    );

    credit_link_tx #(
        .link_credits(link_credits)
    ) u_link_tx (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_empty    (tx_empty),
        .front_flit    (tx_front),
        .credit_granted(credit_granted),
        .pop           (tx_pop),
        .out_flit      (out_flit),
        .data_ready_out(data_ready_out)
    );

    flit_fifo #(
        .depth(rx_depth)
    ) u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (data_ready_in),
        .push_flit (in_flit),
        .pop       (rx_pop),
        .front_flit(rx_front),
        .full      (rx_full),
        .empty     (rx_empty),
        .count     (rx_count)
    );

    rx_reader #(
        .addr_width(addr_width)
    ) u_rx_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .ren          (ren),
        .addr         (addr),
        .data_ready_in(data_ready_in),
        .fifo_full    (rx_full),
        .fifo_empty   (rx_empty),
        .fifo_count   (rx_count),
        .front_flit   (rx_front),
        .pop          (rx_pop),
        .rdata        (rdata),
        .rd_error     (rd_error),
        .credit_return(credit_return)
    );

endmodule

//--- bench/endpoint_node_assert.sv
`timescale 1ns/1ps

module endpoint_node_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       check_link,
    input logic       data_ready_out,
    input logic [7:0] credits,
    input logic [7:0] credit_max,
    input logic       check_fifo,
    input logic       push,
    input logic       pop,
    input logic       full,
    input logic [7:0] count
);

    // a flit leaves only on a spent credit.
    a_send_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        check_link && data_ready_out |-> $past(credits) != 8'd0)
        else $error("data_ready_out without credit");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        check_link |-> credits <= credit_max)
        else $error("credit count above limit");

    a_full_push_held: assert property (@(posedge clk) disable iff (!rst_n)
        check_fifo && push && full && !pop |=> count == $past(count))
        else $error("fifo count moved on push while full");

endmodule

bind credit_link_tx endpoint_node_assert u_link_assert (
    .clk(clk), .rst_n(rst_n), .check_link(1'b1), .data_ready_out(data_ready_out),
    .credits(8'(credits)), .credit_max(8'(link_credits)), .check_fifo(1'b0),
    .push(1'b0), .pop(1'b0), .full(1'b0), .count(8'd0)
);

bind flit_fifo endpoint_node_assert u_fifo_assert (
    .clk(clk), .rst_n(rst_n), .check_link(1'b0), .data_ready_out(1'b0),
    .credits(8'd0), .credit_max(8'd0), .check_fifo(1'b1),
    .push(push), .pop(pop), .full(full), .count(8'(count))
);

//--- bench/endpoint_node_tb.sv
`timescale 1ns/1ps

module endpoint_node_tb
    import chiplet_pkg::*;
;

    localparam int node_id   = 1;
    localparam int rx_depth  = 8;
    localparam int max_ops   = 160;

    typedef enum int {op_write, op_read, op_credit, op_inject, op_idle, op_sent, op_end} op_e;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wen;
    logic        ren;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strobe;
    logic [31:0] rdata;
    logic        error;
    logic        request_stall;
    flit_t       in_flit;
    logic        data_ready_in;
    flit_t       out_flit;
    logic        data_ready_out;
    logic        credit_granted;
    logic        credit_return;

    // stimulus table.
    op_e         t_op [max_ops];
    logic [31:0] t_addr [max_ops];
    logic [31:0] t_data [max_ops];
    logic [3:0]  t_strobe [max_ops];
    int          t_err [max_ops];
    logic [31:0] t_rdata [max_ops];
    int          t_stall [max_ops];  // 2 means either way.
    int          n_ops = 0;
    string       test_name [6] = '{"", "packet out", "credit back-pressure", "rx readback",
                                   "bus errors", "rx overflow"};

    logic [33:0] exp_q [$];
    logic [31:0] seed = 32'hab18c958;
    logic [31:0] rx_words [16];
    int          errors = 0;
    int          sent_count = 0;
    int          seen_credits = 0;
    int          exp_credits = 0;
    int          cycles = 0;
    int          limit = 1000;

    endpoint_node #(
        .node_id (node_id),
        .rx_depth(rx_depth)
    ) u_endpoint_node (
        .clk(clk), .rst_n(rst_n), .wen(wen), .ren(ren), .addr(addr), .wdata(wdata),
        .strobe(strobe), .rdata(rdata), .error(error), .request_stall(request_stall),
        .in_flit(in_flit), .data_ready_in(data_ready_in), .out_flit(out_flit),
        .data_ready_out(data_ready_out), .credit_granted(credit_granted),
        .credit_return(credit_return)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] head_word(input int dest, input int len);
        return {4'(dest), 4'hf, 8'(len), 16'hbeef};  // src and reserved get replaced.
    endfunction

    // count in the low byte, then overflow, empty and front kind.
    function automatic logic [31:0] status_word(input int cnt, input int ovf, input int emp,
                                                input int kind);
        return (32'(kind) << 10) | (32'(emp) << 9) | (32'(ovf) << 8) | 32'(cnt);
    endfunction

    task automatic add_op(input op_e op, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s, input int err, input logic [31:0] rd,
                          input int stall);
        t_op[n_ops]     = op;
        t_addr[n_ops]   = a;
        t_data[n_ops]   = d;
        t_strobe[n_ops] = s;
        t_err[n_ops]    = err;
        t_rdata[n_ops]  = rd;
        t_stall[n_ops]  = stall;
        n_ops++;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 2; i++) begin
            add_op(op_write, 0, head_word(3 + 2 * i, 3 + 11 * i), 4'hf, 0, 0, 0);
            for (int b = 0; b < 3 + 11 * i; b++) begin
                add_op(op_write, 4, lcg_next(), 4'hf, 0, 0, (b == 11) ? 1 : (b > 11) ? 2 : 0);
                if (b == 10) begin
                    add_op(op_idle, 0, 6, 0, 0, 0, 0);
                    add_op(op_sent, 0, 8, 0, 0, 0, 0);  // credits ran out.
                end
            end
            add_op(op_idle, 0, 6, 0, 0, 0, 0);
            if (i == 0) add_op(op_sent, 0, 4, 0, 0, 0, 0);
            for (int c = 0; c < 4 + 12 * i; c++) add_op(op_credit, 0, 0, 0, 0, 0, 0);
            add_op(op_idle, 0, 4, 0, 0, 0, 0);
            for (int c = 0; c < 4 * i; c++) add_op(op_credit, 0, 0, 0, 0, 0, 0);
            add_op(op_end, 0, i + 1, 0, 0, 0, 0);
        end
        for (int k = 0; k < 10; k++) rx_words[k] = lcg_next();
        for (int k = 0; k < 3; k++) add_op(op_inject, 0, rx_words[k], 0, 0, 0, 0);
        add_op(op_read, 8'h14, 0, 0, 0, status_word(3, 0, 0, 1), 0);
        for (int k = 0; k < 3; k++) add_op(op_read, 8'h10, 0, 0, 0, rx_words[k], 0);
        add_op(op_read, 8'h14, 0, 0, 0, status_word(0, 0, 1, 0), 0);
        add_op(op_end, 0, 3, 0, 0, 0, 0);
        add_op(op_write, 4, 32'h1234, 4'hf, 1, 0, 0);
        add_op(op_write, 0, head_word(2, 0), 4'hf, 1, 0, 0);
        add_op(op_write, 0, head_word(2, 1), 4'hf, 0, 0, 0);
        add_op(op_write, 0, head_word(2, 2), 4'hf, 1, 0, 0);
        add_op(op_write, 8'h08, 32'h55, 4'hf, 1, 0, 0);
        add_op(op_write, 4, 32'h66, 4'b0111, 1, 0, 0);
        add_op(op_write, 4, 32'h77, 4'hf, 0, 0, 0);
        add_op(op_read, 8'h20, 0, 0, 1, 0, 0);
        add_op(op_read, 8'h10, 0, 0, 1, 0, 0);
        add_op(op_read, 8'h14, 0, 0, 0, status_word(0, 0, 1, 0), 0);
        add_op(op_idle, 0, 6, 0, 0, 0, 0);
        add_op(op_end, 0, 4, 0, 0, 0, 0);
        for (int k = 0; k < rx_depth + 2; k++) add_op(op_inject, 0, rx_words[k], 0, 0, 0, 0);
        add_op(op_read, 8'h14, 0, 0, 0, status_word(rx_depth, 1, 0, 1), 0);
        for (int k = 0; k < rx_depth; k++) add_op(op_read, 8'h10, 0, 0, 0, rx_words[k], 0);
        add_op(op_read, 8'h14, 0, 0, 0, status_word(0, 1, 1, 0), 0);
        add_op(op_end, 0, 5, 0, 0, 0, 0);
    endtask

    // scoreboard side of the link and the credit returns.
    always @(negedge clk) begin
        if (rst_n && data_ready_out) begin
            sent_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("flit appeared on out_flit at %0t with none predicted", $time);
            end else begin
                check_value("out_flit", out_flit, exp_q.pop_front());
            end
        end
        if (rst_n && credit_return) seen_credits++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [7:0]  m_rem;
        logic [33:0] f;
        int          stall_seen;
        int          test_err;
        int          passed;
        int          failed;

        m_rem = 0;
        test_err = 0;
        passed = 0;
        failed = 0;
        rst_n = 0;
        wen = 0;
        ren = 0;
        addr = 0;
        wdata = 0;
        strobe = 0;
        in_flit = '0;
        data_ready_in = 0;
        credit_granted = 0;
        build_table();
        limit = 10 * n_ops + 200;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            @(posedge clk);
            wen            <= 1'b0;
            ren            <= 1'b0;
            data_ready_in  <= 1'b0;
            credit_granted <= 1'b0;
            case (t_op[i])
                op_write: begin
                    wen    <= 1'b1;
                    addr   <= t_addr[i];
                    wdata  <= t_data[i];
                    strobe <= t_strobe[i];
                    stall_seen = 0;
                    @(negedge clk);
                    while (request_stall) begin
                        stall_seen = 1;
                        @(posedge clk);
                        credit_granted <= 1'b1;  // free the link while held.
                        @(negedge clk);
                    end
                    if (t_stall[i] != 2) check_value("request_stall", stall_seen, t_stall[i]);
                    check_value("error", error, t_err[i]);
                    if (t_err[i] == 0) begin
                        if (t_addr[i] == 0) begin
                            f = {2'(kind_head), t_data[i][31:28], 4'(node_id),
                                 t_data[i][23:16], 16'h0};
                            m_rem = t_data[i][23:16];
                        end else begin
                            f = {(m_rem == 1) ? 2'(kind_tail) : 2'(kind_body), t_data[i]};
                            m_rem = m_rem - 1;
                        end
                        exp_q.push_back(f);
                    end
                end
                op_read: begin
                    ren  <= 1'b1;
                    addr <= t_addr[i];
                    @(negedge clk);
                    check_value("error", error, t_err[i]);
                    check_value("rdata", rdata, t_rdata[i]);
                    if (t_err[i] == 0 && t_addr[i] == 8'h10) exp_credits++;
                end
                op_credit: credit_granted <= 1'b1;
                op_inject: begin
                    data_ready_in        <= 1'b1;
                    in_flit.kind         <= kind_body;
                    in_flit.payload.data <= t_data[i];
                end
                op_idle: repeat (t_data[i] - 1) @(posedge clk);
                op_sent: check_value("flits sent", sent_count, t_data[i]);
                op_end: begin
                    while (exp_q.size() != 0) @(posedge clk);
                    repeat (2) @(negedge clk);
                    check_value("credit_return count", seen_credits, exp_credits);
                    if (errors == test_err) passed++;
                    else failed++;
                    $display("test %0d %s: %s", t_data[i], test_name[t_data[i]],
                             (errors == test_err) ? "pass" : "fail");
                    test_err = errors;
                end
                default: ;
            endcase
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
common/chiplet_pkg.sv
hdl/flit_fifo.sv
endpoint/flit_packetizer.sv
endpoint/rx_reader.sv
hdl/credit_link_tx.sv
hdl/endpoint_node.sv
bench/endpoint_node_assert.sv
bench/endpoint_node_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the endpoint_node testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module endpoint_node_tb \
    -o sim_endpoint_node > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_endpoint_node > sim.log 2>&1 ; cat sim.log

grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
